/* Bender.yml */
package:
  name: ooo_cpu

sources:
  - files:
      - hw/cpu_pkg.sv
      - hw/fetch.sv
      - hw/decoder.sv
      - hw/dispatch_rename.sv
      - hw/rs.sv
      - hw/execute.sv
      - hw/rob.sv
      - hw/cpu.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/cpu_asserts.sv
      - testbench/cpu_tb.sv

/* build.f */
hw/cpu_pkg.sv
hw/fetch.sv
hw/decoder.sv
hw/dispatch_rename.sv
hw/rs.sv
hw/execute.sv
hw/rob.sv
hw/cpu.sv
testbench/tb_clock.sv
testbench/cpu_asserts.sv
testbench/cpu_tb.sv

/* hw/cpu.sv */
// Top level of the out-of-order core; connects fetch, decode, rename, RS, execute and ROB
`timescale 1ns/1ps

module cpu import cpu_pkg::*; (
    input  logic           clock,
    input  logic           rst_n,
    input  inst_t          inst,      // Word at pc, same cycle
    output addr_t          pc,
    output commit_packet_t commit     // One strobe per retired instruction
);

    fetch_packet_t  fetch_pkt;
    decode_packet_t decode_pkt;
    logic           stall;
    logic           dispatch;
    rs_packet_t     rs_entry;
    rob_packet_t    rob_entry;
    logic           rs_full;
    logic           rob_full;
    rob_idx_t       rob_tail;
    issue_packet_t  issue_pkt;
    cdb_packet_t    cdb;
    retire_packet_t retire_pkt;

    ////////////////////////////////////////////////////////////
    // In-order front end
    ////////////////////////////////////////////////////////////

    fetch u_fetch (
        .clock     (clock),
        .rst_n     (rst_n),
        .inst      (inst),
        .stall     (stall),
        .pc        (pc),
        .fetch_out (fetch_pkt)
    );

    decoder u_decoder (
        .fetch_in   (fetch_pkt),
        .decode_out (decode_pkt)
    );

    dispatch_rename u_dispatch (
        .clock     (clock),
        .rst_n     (rst_n),
        .decode_in (decode_pkt),
        .rob_full  (rob_full),
        .rs_full   (rs_full),
        .rob_tail  (rob_tail),
        .cdb       (cdb),
        .retire_in (retire_pkt),
        .stall     (stall),
        .dispatch  (dispatch),
        .rs_entry  (rs_entry),
        .rob_entry (rob_entry)
    );

    ////////////////////////////////////////////////////////////
    // Out-of-order back end
    ////////////////////////////////////////////////////////////

    rs u_rs (
        .clock     (clock),
        .rst_n     (rst_n),
        .dispatch  (dispatch),
        .rs_entry  (rs_entry),
        .cdb       (cdb),
        .rs_full   (rs_full),
        .issue_out (issue_pkt)
    );

    execute u_execute (
        .clock    (clock),
        .rst_n    (rst_n),
        .issue_in (issue_pkt),
        .cdb      (cdb)
    );

    rob u_rob (
        .clock      (clock),
        .rst_n      (rst_n),
        .dispatch   (dispatch),
        .rob_entry  (rob_entry),
        .cdb        (cdb),
        .rob_tail   (rob_tail),
        .rob_full   (rob_full),
        .retire_out (retire_pkt),
        .commit     (commit)
    );

endmodule

/* hw/cpu_pkg.sv */
// Shared sizes, instruction views and stage packets for the out-of-order core; import into each stage
package cpu_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes and encodings
    ////////////////////////////////////////////////////////////

    localparam int XLEN      = 32;
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;   // Pregs 0..31 hold the reset mapping
    localparam int ROB_SIZE  = 8;    // Power of two so pointers wrap for free
    localparam int RS_SIZE   = 4;

    localparam logic [6:0] OPC_OP     = 7'b0110011;   // R-type ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;   // I-type ALU

    typedef logic [XLEN-1:0] data_t;
    typedef logic [XLEN-1:0] addr_t;
    typedef logic [4:0]      arch_reg_t;
    typedef logic [5:0]      phys_reg_t;
    typedef logic [2:0]      rob_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    ////////////////////////////////////////////////////////////
    // Instruction word, two views of the same 32 bits
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        arch_reg_t  rs2;
        arch_reg_t  rs1;
        logic [2:0] funct3;
        arch_reg_t  rd;
        logic [6:0] opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0] imm;     // Sign extended in decode
        arch_reg_t   rs1;
        logic [2:0]  funct3;
        arch_reg_t   rd;
        logic [6:0]  opcode;
    } i_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_t;

    ////////////////////////////////////////////////////////////
    // Stage packets
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic  valid;
        addr_t pc;
        inst_t inst;
    } fetch_packet_t;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        alu_op_t   alu_op;
        logic      uses_imm;     // Second operand is imm
        data_t     imm;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
        logic      dest_valid;   // Low for rd zero
    } decode_packet_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      uses_imm;
        data_t     imm;
        phys_reg_t src1;
        phys_reg_t src2;
        logic      src1_ready;
        logic      src2_ready;
        phys_reg_t dest_preg;    // Preg 0 for x0 writes
        rob_idx_t  rob_idx;
    } rs_packet_t;

    typedef struct packed {
        logic      valid;
        alu_op_t   alu_op;
        logic      uses_imm;
        data_t     imm;
        phys_reg_t src1;
        phys_reg_t src2;
        phys_reg_t dest_preg;
        rob_idx_t  rob_idx;
    } issue_packet_t;

    typedef struct packed {
        logic      valid;
        phys_reg_t dest_preg;
        rob_idx_t  rob_idx;
        data_t     value;
    } cdb_packet_t;

    typedef struct packed {
        addr_t     pc;
        arch_reg_t arch_dest;
        logic      dest_valid;
        phys_reg_t old_preg;     // Mapping replaced by this instruction
    } rob_packet_t;

    typedef struct packed {
        logic      valid;
        phys_reg_t old_preg;
        logic      dest_valid;
    } retire_packet_t;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        arch_reg_t arch_dest;
        logic      dest_valid;
        data_t     value;
    } commit_packet_t;

endpackage

/* hw/decoder.sv */
// Combinational decoder from the fetch register to the dispatch packet; unknown words become nops
`timescale 1ns/1ps

module decoder import cpu_pkg::*; (
    input  fetch_packet_t  fetch_in,
    output decode_packet_t decode_out
);

    inst_t   inst;
    logic    r_known;    // funct7/funct3 pair is one of the five R ops
    alu_op_t r_op;

    assign inst = fetch_in.inst;

    // R-type operation select
    always_comb begin
        r_known = 1'b1;
        case ({inst.r.funct7, inst.r.funct3})
            {7'h00, 3'h0}: r_op = ALU_ADD;
            {7'h20, 3'h0}: r_op = ALU_SUB;
            {7'h00, 3'h7}: r_op = ALU_AND;
            {7'h00, 3'h6}: r_op = ALU_OR;
            {7'h00, 3'h4}: r_op = ALU_XOR;
            default: begin
                r_op    = ALU_ADD;
                r_known = 1'b0;
            end
        endcase
    end

    always_comb begin
        decode_out          = '0;      // Default is ADDI x0, x0, 0
        decode_out.valid    = fetch_in.valid;
        decode_out.pc       = fetch_in.pc;
        decode_out.alu_op   = ALU_ADD;
        decode_out.uses_imm = 1'b1;
        if (inst.r.opcode == OPC_OP && r_known) begin
            decode_out.alu_op   = r_op;
            decode_out.uses_imm = 1'b0;
            decode_out.rs1      = inst.r.rs1;
            decode_out.rs2      = inst.r.rs2;
            decode_out.rd       = inst.r.rd;
        end else if (inst.i.opcode == OPC_OP_IMM && inst.i.funct3 == 3'h0) begin
            decode_out.imm = {{(XLEN-12){inst.i.imm[11]}}, inst.i.imm};   // ADDI
            decode_out.rs1 = inst.i.rs1;
            decode_out.rd  = inst.i.rd;
        end
        decode_out.dest_valid = (decode_out.rd != '0);   // x0 is never renamed
    end

endmodule

/* hw/dispatch_rename.sv */
// Rename and dispatch: map table, free list and complete list feeding the ROB and RS
`timescale 1ns/1ps

module dispatch_rename import cpu_pkg::*; (
    input  logic           clock,
    input  logic           rst_n,
    input  decode_packet_t decode_in,
    input  logic           rob_full,
    input  logic           rs_full,
    input  rob_idx_t       rob_tail,
    input  cdb_packet_t    cdb,
    input  retire_packet_t retire_in,
    output logic           stall,
    output logic           dispatch,
    output rs_packet_t     rs_entry,
    output rob_packet_t    rob_entry
);

    phys_reg_t            map_table [ARCH_REGS];
    logic [PHYS_REGS-1:0] free_list;       // One bit per preg, set when free
    logic [PHYS_REGS-1:0] complete_list;   // Set when the value is in the regfile
    phys_reg_t            new_preg;
    phys_reg_t            src1;
    phys_reg_t            src2;
    logic                 alloc;

    // Lowest numbered free preg
    always_comb begin
        new_preg = '0;
        for (int i = PHYS_REGS - 1; i >= 0; i--) begin
            if (free_list[i]) begin
                new_preg = phys_reg_t'(i);
            end
        end
    end

    assign stall    = rob_full | rs_full | ~|free_list;
    assign dispatch = decode_in.valid & ~stall;
    assign alloc    = dispatch & decode_in.dest_valid;
    assign src1     = map_table[decode_in.rs1];
    assign src2     = map_table[decode_in.rs2];

    always_comb begin
        rs_entry.alu_op     = decode_in.alu_op;
        rs_entry.uses_imm   = decode_in.uses_imm;
        rs_entry.imm        = decode_in.imm;
        rs_entry.src1       = src1;
        rs_entry.src2       = src2;
        // Ready if complete, or its tag is on the CDB right now
        rs_entry.src1_ready = complete_list[src1] | (cdb.valid && cdb.dest_preg == src1);
        rs_entry.src2_ready = complete_list[src2] | (cdb.valid && cdb.dest_preg == src2)
                            | decode_in.uses_imm;   // No second register
        rs_entry.dest_preg  = decode_in.dest_valid ? new_preg : '0;   // x0 goes to preg 0
        rs_entry.rob_idx    = rob_tail;

        rob_entry.pc         = decode_in.pc;
        rob_entry.arch_dest  = decode_in.rd;
        rob_entry.dest_valid = decode_in.dest_valid;
        rob_entry.old_preg   = map_table[decode_in.rd];   // Freed when this retires
    end

    ////////////////////////////////////////////////////////////
    // Rename state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_table[i] <= phys_reg_t'(i);   // Identity mapping
            end
            free_list     <= {{(PHYS_REGS-ARCH_REGS){1'b1}}, {ARCH_REGS{1'b0}}};
            complete_list <= {{(PHYS_REGS-ARCH_REGS){1'b0}}, {ARCH_REGS{1'b1}}};
        end else begin
            if (alloc) begin
                map_table[decode_in.rd] <= new_preg;
                free_list[new_preg]     <= 1'b0;
                complete_list[new_preg] <= 1'b0;   // Pending until its CDB
            end
            if (cdb.valid) begin
                complete_list[cdb.dest_preg] <= 1'b1;
            end
            if (retire_in.valid && retire_in.dest_valid) begin
                free_list[retire_in.old_preg] <= 1'b1;   // Recycle old mapping
            end
        end
    end

endmodule

/* hw/execute.sv */
// ALU execute stage: physical register file read, ALU, registered CDB broadcast
`timescale 1ns/1ps

module execute import cpu_pkg::*; (
    input  logic          clock,
    input  logic          rst_n,
    input  issue_packet_t issue_in,
    output cdb_packet_t   cdb
);

    data_t rf [PHYS_REGS];
    data_t op1;
    data_t op2;
    data_t opb;        // Second ALU operand after imm select
    data_t result;

    // Bypass the CDB value that the regfile takes at this edge
    assign op1 = (cdb.valid && cdb.dest_preg == issue_in.src1) ? cdb.value : rf[issue_in.src1];
    assign op2 = (cdb.valid && cdb.dest_preg == issue_in.src2) ? cdb.value : rf[issue_in.src2];
    assign opb = issue_in.uses_imm ? issue_in.imm : op2;

    always_comb begin
        case (issue_in.alu_op)
            ALU_ADD: result = op1 + opb;
            ALU_SUB: result = op1 - opb;
            ALU_AND: result = op1 & opb;
            ALU_OR:  result = op1 | opb;
            ALU_XOR: result = op1 ^ opb;
            default: result = op1 + opb;
        endcase
        if (issue_in.dest_preg == '0) begin
            result = '0;   // Preg 0 is x0 and stays zero
        end
    end

    ////////////////////////////////////////////////////////////
    // CDB register and regfile write
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cdb <= '0;
        end else begin
            cdb.valid     <= issue_in.valid;   // One cycle after issue
            cdb.dest_preg <= issue_in.dest_preg;
            cdb.rob_idx   <= issue_in.rob_idx;
            cdb.value     <= result;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                rf[i] <= '0;   // Architectural state starts at zero
            end
        end else if (cdb.valid) begin
            rf[cdb.dest_preg] <= cdb.value;
        end
    end

endmodule

/* hw/fetch.sv */
// Fetch stage: PC register and single fetch register, both held while dispatch stalls
`timescale 1ns/1ps

module fetch import cpu_pkg::*; (
    input  logic          clock,
    input  logic          rst_n,
    input  inst_t         inst,        // Memory word at pc, same cycle
    input  logic          stall,       // Back-pressure from dispatch
    output addr_t         pc,
    output fetch_packet_t fetch_out
);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= '0;
            fetch_out <= '0;
        end else if (!stall) begin
            fetch_out.valid <= 1'b1;   // Valid from the first edge on
            fetch_out.pc    <= pc;
            fetch_out.inst  <= inst;
            pc              <= pc + 32'd4;   // Sequential only, no branches
        end
    end

endmodule

/* hw/rob.sv */
// Reorder buffer: circular queue filled at dispatch, completed by CDB, retired in order
`timescale 1ns/1ps

module rob import cpu_pkg::*; (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           dispatch,
    input  rob_packet_t    rob_entry,
    input  cdb_packet_t    cdb,
    output rob_idx_t       rob_tail,
    output logic           rob_full,
    output retire_packet_t retire_out,
    output commit_packet_t commit
);

    rob_packet_t               entry [ROB_SIZE];
    data_t                     value [ROB_SIZE];   // Result from the CDB
    logic [ROB_SIZE-1:0]       done;
    rob_idx_t                  head;
    logic [$clog2(ROB_SIZE):0] count;              // 0 to ROB_SIZE
    logic                      retire;

    assign rob_full = (count == ROB_SIZE);
    assign retire   = (count != '0) && done[head];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head       <= '0;
            rob_tail   <= '0;
            count      <= '0;
            done       <= '0;
            commit     <= '0;
            retire_out <= '0;
        end else begin
            if (dispatch) begin
                done[rob_tail] <= 1'b0;
                rob_tail       <= rob_tail + 1'b1;   // Wraps at ROB_SIZE
            end
            if (cdb.valid) begin
                done[cdb.rob_idx] <= 1'b1;
            end
            commit.valid     <= retire;   // Single-cycle strobe
            retire_out.valid <= retire;
            if (retire) begin
                head                  <= head + 1'b1;
                commit.pc             <= entry[head].pc;
                commit.arch_dest      <= entry[head].arch_dest;
                commit.dest_valid     <= entry[head].dest_valid;
                commit.value          <= value[head];
                retire_out.old_preg   <= entry[head].old_preg;
                retire_out.dest_valid <= entry[head].dest_valid;
            end
            case ({dispatch, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Payload
    always_ff @(posedge clock) begin
        if (dispatch) begin
            entry[rob_tail] <= rob_entry;
        end
        if (cdb.valid) begin
            value[cdb.rob_idx] <= cdb.value;
        end
    end

endmodule

/* hw/rs.sv */
// Four-entry reservation station kept in age order; CDB wakeup and oldest-ready issue
`timescale 1ns/1ps

module rs import cpu_pkg::*; (
    input  logic          clock,
    input  logic          rst_n,
    input  logic          dispatch,
    input  rs_packet_t    rs_entry,
    input  cdb_packet_t   cdb,
    output logic          rs_full,
    output issue_packet_t issue_out
);

    rs_packet_t                 slot      [RS_SIZE];   // Slot 0 is the oldest
    rs_packet_t                 slot_next [RS_SIZE];
    rs_packet_t                 woke      [RS_SIZE];   // Slots with this CDB applied
    logic [RS_SIZE-1:0]         valid;
    logic [RS_SIZE-1:0]         valid_next;
    logic [RS_SIZE-1:0]         ready;
    logic [$clog2(RS_SIZE)-1:0] sel;
    logic                       issue;

    // Wakeup
    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            woke[i] = slot[i];
            if (cdb.valid && cdb.dest_preg == slot[i].src1) begin
                woke[i].src1_ready = 1'b1;
            end
            if (cdb.valid && cdb.dest_preg == slot[i].src2) begin
                woke[i].src2_ready = 1'b1;
            end
            ready[i] = valid[i] && woke[i].src1_ready && woke[i].src2_ready;
        end
    end

    // Oldest ready slot wins
    always_comb begin
        sel   = '0;
        issue = |ready;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (ready[i]) begin
                sel = i[$clog2(RS_SIZE)-1:0];
            end
        end
    end

    always_comb begin
        issue_out.valid     = issue;
        issue_out.alu_op    = slot[sel].alu_op;
        issue_out.uses_imm  = slot[sel].uses_imm;
        issue_out.imm       = slot[sel].imm;
        issue_out.src1      = slot[sel].src1;
        issue_out.src2      = slot[sel].src2;
        issue_out.dest_preg = slot[sel].dest_preg;
        issue_out.rob_idx   = slot[sel].rob_idx;
    end

    // Collapse out the issued slot, then append the new entry
    always_comb begin
        int k;
        k          = 0;
        valid_next = '0;
        slot_next  = woke;
        for (int i = 0; i < RS_SIZE; i++) begin
            if (valid[i] && !(issue && sel == i)) begin
                slot_next[k]  = woke[i];
                valid_next[k] = 1'b1;
                k++;
            end
        end
        if (dispatch) begin   // Never while full
            slot_next[k]  = rs_entry;
            valid_next[k] = 1'b1;
        end
    end

    assign rs_full = &valid;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else begin
            valid <= valid_next;
        end
    end

    always_ff @(posedge clock) begin
        slot <= slot_next;
    end

endmodule

/* testbench/cpu_asserts.sv */
// Concurrent checks on the commit stream and fetch pc timing; bound into the core top level
`timescale 1ns/1ps

module cpu_asserts import cpu_pkg::*; (
    input logic           clock,
    input logic           rst_n,
    input addr_t          pc,
    input commit_packet_t commit,
    input logic           stall
);

    addr_t last_pc;      // pc of the previous commit
    logic  have_last;    // At least one commit since reset

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            last_pc   <= '0;
            have_last <= 1'b0;
        end else if (commit.valid) begin
            last_pc   <= commit.pc;
            have_last <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Properties
    ////////////////////////////////////////////////////////////

    reset_quiet: assert property (@(posedge clock) !rst_n |-> !commit.valid)
        else $error("commit strobe seen while reset is asserted");

    // Sequential program, so retirement walks pc in steps of one word
    commit_in_order: assert property (@(posedge clock) disable iff (!rst_n)
        (commit.valid && have_last) |-> (commit.pc == last_pc + 32'd4))
        else $error("commit pc does not follow the previous commit");

    fetch_hold: assert property (@(posedge clock) disable iff (!rst_n)
        stall |=> $stable(pc))
        else $error("pc moved while dispatch was stalled");

    // Fetch steps one word per cycle whenever dispatch accepts
    fetch_advance: assert property (@(posedge clock) disable iff (!rst_n)
        !stall |=> (pc == $past(pc) + 32'd4))
        else $error("pc did not advance by one word without a stall");

endmodule

bind cpu cpu_asserts u_asserts (
    .clock  (clock),
    .rst_n  (rst_n),
    .pc     (pc),
    .commit (commit),
    .stall  (stall)
);

/* testbench/cpu_tb.sv */
// Top testbench for the core; program memory, in-order reference model and directed tests
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

    logic           clock;
    logic           rst_n;
    logic           restart;          // Pulse for a fresh reset per test
    inst_t          inst;
    addr_t          pc;
    commit_packet_t commit;

    logic [31:0] prog    [128];       // Program words indexed by pc / 4
    int          prog_len;
    logic [31:0] exp_pc  [128];       // Expected commit stream from the model
    logic [4:0]  exp_rd  [128];
    logic        exp_dv  [128];
    logic [31:0] exp_val [128];
    int          errors;
    int          timeouts;

    tb_clock clock_gen (
        .restart (restart),
        .clock   (clock),
        .rst_n   (rst_n)
    );

    cpu UUT (
        .clock  (clock),
        .rst_n  (rst_n),
        .inst   (inst),
        .pc     (pc),
        .commit (commit)
    );

    ////////////////////////////////////////////////////////////
    // Instruction encoding and program memory
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] r_word(input alu_op_t op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        logic [6:0] funct7;
        logic [2:0] funct3;
        funct7 = 7'h00;
        funct3 = 3'h0;
        case (op)
            ALU_SUB: funct7 = 7'h20;
            ALU_AND: funct3 = 3'h7;
            ALU_OR:  funct3 = 3'h6;
            ALU_XOR: funct3 = 3'h4;
            default: funct3 = 3'h0;   // ADD
        endcase
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'h0, rd, 7'b0010011};
    endfunction

    task automatic emit_word(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    // Memory word at pc driven on the falling edge
    always @(negedge clock) begin
        if (pc[31:2] < prog_len) begin
            inst = prog[pc[31:2]];
        end else begin
            inst = addi_word(5'd0, 5'd0, 12'd0);   // Padding nop
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model and checking
    ////////////////////////////////////////////////////////////

    // Runs the program in order on an architectural register file
    task automatic build_expected;
        logic [31:0] regs [32];
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic [4:0]  dest;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        for (int n = 0; n < prog_len; n++) begin
            w    = prog[n];
            a    = regs[w[19:15]];
            b    = regs[w[24:20]];
            imm  = {{20{w[31]}}, w[31:20]};
            res  = '0;
            dest = 5'd0;                        // Unknown words act as nops
            if (w[6:0] == 7'b0110011) begin
                dest = w[11:7];
                case ({w[31:25], w[14:12]})
                    {7'h00, 3'h0}: res = a + b;
                    {7'h20, 3'h0}: res = a - b;
                    {7'h00, 3'h7}: res = a & b;
                    {7'h00, 3'h6}: res = a | b;
                    {7'h00, 3'h4}: res = a ^ b;
                    default:       dest = 5'd0;
                endcase
            end else if (w[6:0] == 7'b0010011 && w[14:12] == 3'h0) begin
                dest = w[11:7];
                res  = a + imm;
            end
            if (dest == 5'd0) begin
                res = '0;                       // x0 is hardwired zero
            end else begin
                regs[dest] = res;
            end
            exp_pc[n]  = 32'(n * 4);
            exp_rd[n]  = dest;
            exp_dv[n]  = (dest != 5'd0);
            exp_val[n] = res;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    // Resets the core, then compares each commit strobe against the model
    task automatic run_program(input string name);
        logic seen_low;
        logic released;
        int   idx;
        int   cycles;
        build_expected();
        seen_low = 1'b0;
        released = 1'b0;
        @(negedge clock);
        restart = 1'b1;
        for (int c = 0; c < 10 && !released; c++) begin
            @(posedge clock);
            if (!rst_n) begin
                seen_low = 1'b1;
                check_value("commit.valid", commit.valid, 32'd0);   // Quiet in reset
                check_value("pc", pc, 32'd0);
            end else if (seen_low) begin
                released = 1'b1;
            end
        end
        restart = 1'b0;
        if (!released) begin
            timeouts++;
            $display("Timeout in %s: reset was never released", name);
            return;
        end
        idx    = 0;
        cycles = 0;
        while (idx < prog_len && cycles < prog_len * 30 + 100) begin
            @(negedge clock);
            cycles++;
            if (commit.valid) begin
                check_value("commit.pc", commit.pc, exp_pc[idx]);
                check_value("commit.arch_dest", commit.arch_dest, exp_rd[idx]);
                check_value("commit.dest_valid", commit.dest_valid, exp_dv[idx]);
                check_value("commit.value", commit.value, exp_val[idx]);
                idx++;
            end
        end
        if (idx < prog_len) begin
            timeouts++;
            $display("Timeout in %s: saw only %0d of %0d commits", name, idx, prog_len);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic first_commit_after_reset;
        prog_len = 0;
        emit_word(addi_word(5'd1, 5'd0, 12'd11));
        emit_word(addi_word(5'd2, 5'd0, 12'd22));
        emit_word(r_word(ALU_ADD, 5'd3, 5'd1, 5'd2));
        run_program("reset and first commit");
    endtask

    task automatic independent_ops;
        prog_len = 0;
        emit_word(addi_word(5'd1, 5'd0, 12'd100));
        emit_word(addi_word(5'd2, 5'd0, 12'hff9));   // -7
        emit_word(addi_word(5'd3, 5'd0, 12'h5a5));
        emit_word(addi_word(5'd4, 5'd0, 12'h0f0));
        emit_word(r_word(ALU_ADD, 5'd5, 5'd1, 5'd2));
        emit_word(r_word(ALU_SUB, 5'd6, 5'd3, 5'd4));
        emit_word(r_word(ALU_AND, 5'd7, 5'd3, 5'd4));
        emit_word(r_word(ALU_OR,  5'd8, 5'd1, 5'd4));
        emit_word(r_word(ALU_XOR, 5'd9, 5'd2, 5'd3));
        run_program("independent operations");
    endtask

    // Each result feeds the next, so wakeup and bypass carry the values
    task automatic dependent_chain;
        prog_len = 0;
        emit_word(addi_word(5'd1, 5'd0, 12'd3));
        emit_word(r_word(ALU_ADD, 5'd2, 5'd1, 5'd1));
        emit_word(r_word(ALU_SUB, 5'd3, 5'd2, 5'd1));
        emit_word(r_word(ALU_XOR, 5'd4, 5'd3, 5'd2));
        emit_word(r_word(ALU_OR,  5'd5, 5'd4, 5'd1));
        emit_word(r_word(ALU_AND, 5'd6, 5'd5, 5'd2));
        emit_word(addi_word(5'd6, 5'd6, 12'hfff));
        emit_word(r_word(ALU_ADD, 5'd7, 5'd6, 5'd6));
        emit_word(r_word(ALU_ADD, 5'd7, 5'd7, 5'd7));
        emit_word(r_word(ALU_SUB, 5'd1, 5'd7, 5'd6));
        run_program("dependent chain");
    endtask

    // Forty writes to three registers go well past the 32 free pregs
    task automatic preg_recycling;
        logic [4:0] rd;
        logic [4:0] rs;
        prog_len = 0;
        for (int k = 0; k < 40; k++) begin
            rd = 5'(1 + k % 3);
            rs = 5'(1 + (k + 2) % 3);
            if (k % 2 == 1) begin
                emit_word(addi_word(rd, rs, 12'(k)));
            end else begin
                emit_word(r_word(ALU_ADD, rd, rd, rs));
            end
        end
        run_program("physical register recycling");
    endtask

    task automatic x0_writes;
        prog_len = 0;
        emit_word(addi_word(5'd1, 5'd0, 12'd9));
        emit_word(addi_word(5'd0, 5'd1, 12'd5));          // Dropped writes
        emit_word(r_word(ALU_ADD, 5'd0, 5'd1, 5'd1));
        emit_word(r_word(ALU_XOR, 5'd0, 5'd1, 5'd0));
        emit_word(r_word(ALU_ADD, 5'd2, 5'd0, 5'd0));     // Reads of x0 after them
        emit_word(addi_word(5'd3, 5'd0, 12'd4));
        emit_word(r_word(ALU_SUB, 5'd4, 5'd1, 5'd0));
        emit_word(r_word(ALU_OR,  5'd5, 5'd0, 5'd3));
        run_program("writes to x0");
    endtask

    task automatic random_programs;
        int          op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        for (int p = 0; p < 3; p++) begin
            prog_len = 0;
            for (int n = 0; n < 60; n++) begin
                op  = int'($urandom % 6);
                rd  = 5'($urandom % 8);     // Few registers give many hazards
                rs1 = 5'($urandom % 8);
                rs2 = 5'($urandom % 8);
                imm = 12'($urandom);
                if (op == 5) begin
                    emit_word(addi_word(rd, rs1, imm));
                end else begin
                    emit_word(r_word(alu_op_t'(op), rd, rs1, rs2));
                end
            end
            run_program("random program");
        end
    endtask

    initial begin
        errors   = 0;
        timeouts = 0;
        restart  = 1'b0;
        prog_len = 0;
        inst     = addi_word(5'd0, 5'd0, 12'd0);
        void'($urandom(32'h28a0));
        first_commit_after_reset();
        independent_ops();
        dependent_chain();
        preg_recycling();
        x0_writes();
        random_programs();
        $display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* testbench/tb_clock.sv */
// Testbench clock and reset source; 100 ns clock, reset held low two cycles on each restart request
`timescale 1ns/1ps

module tb_clock (
    input  logic restart,    // Rising edge starts a new reset
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        rst_n = 1'b0;        // Held until the first restart completes
    end

    always #50 clock = ~clock;   // 100 ns period

    // Assert on the falling edge and release on a falling edge two cycles later
    always @(posedge restart) begin
        rst_n = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
    end

endmodule
